//--- sim.f
+incdir+verif
hdl/freq_meter_pkg.sv
hdl/gray_tick_counter.sv
hdl/gray_sync_diff.sv
hdl/window_strobe_gen.sv
hdl/gated_accumulator.sv
hdl/freq_meter_top.sv
verif/tb_freq_meter.sv

//--- Makefile
# Verilator flow for the frequency meter testbench
# variables can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_freq_meter
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_LINE ?= >>> PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verif/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# passes only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_LINE)'

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_checks.svh
// compare tasks and expected-count helpers for the frequency meter testbench
// included inside the testbench module after the package import
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// print the reason, then the fail line, then stop the run
task automatic abort_run(input string reason);
	$display("%s", reason);
	$display(">>> FAIL");
	$fatal(1, "stopping at first error");
endtask

// result over a window, tol counts either way
task automatic check_freq(input string name, input freq_t expected, input freq_t actual,
		input int tol);
	int diff;
	diff = int'(actual) - int'(expected);
	if (diff < 0)
		diff = -diff;
	if (diff > tol)
		abort_run($sformatf("Mismatch at %0t: %s expected %0d (+/-%0d) actual %0d",
			$time, name, expected, tol, actual));
endtask

// per-cycle count, exact
task automatic check_xcount(input string name, input xcount_t expected, input xcount_t actual);
	if (actual !== expected)
		abort_run($sformatf("Mismatch at %0t: %s expected %0d actual %0d",
			$time, name, expected, actual));
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	if (actual !== expected)
		abort_run($sformatf("Mismatch at %0t: %s expected %b actual %b",
			$time, name, expected, actual));
endtask

// spacing between strobes in sysclk cycles
task automatic check_gap(input string name, input int expected, input int actual);
	if (actual != expected)
		abort_run($sformatf("Mismatch at %0t: %s expected %0d actual %0d",
			$time, name, expected, actual));
endtask

// window length in sysclk cycles, log2 steps 8, 10, 12, 14
function automatic int window_cycles(input win_sel_t sel);
	return 1 << (8 + 2 * int'(sel));
endfunction

// rising f_in edges over a span of sysclk cycles, rounded to nearest
function automatic freq_t expected_count(input int span, input real period_ns);
	real edges;
	edges = real'(span) * SYSCLK_NS / period_ns;
	return freq_t'($rtoi(edges + 0.5));
endfunction

// most edges that can land inside one sysclk cycle
function automatic int max_per_cycle(input real period_ns);
	return $rtoi($ceil(SYSCLK_NS / period_ns));
endfunction

`endif

//--- verif/tb_freq_meter.sv
// directed testbench for the gated frequency meter, tests run in sequence from one initial
// built and run through the Makefile, sources listed in sim.f
`timescale 1ns/1ps

module tb_freq_meter;
	import freq_meter_pkg::*;

	localparam real SYSCLK_NS = 40.0;
	localparam freq_t NO_DATA = '1;  // frequency before the first full window
	// windows per test: reset, four free-running, gated, partial, window change
	localparam int WINDOW_SUM = 256 + (256 + 1024 + 4096 + 16384) + 256 + 256 + 1024;
	// three windows plus 32 cycles each, about 128 more for the per-cycle test
	localparam int TIMEOUT_CYCLES = 3 * WINDOW_SUM + 32 * 9 + 128;

	logic     sysclk  = 1'b0;
	logic     rst_n   = 1'b0;
	logic     f_in    = 1'b0;
	logic     g_in    = 1'b0;  // gate starts closed
	win_sel_t win_sel = '0;
	freq_t    frequency;
	logic     freq_strobe;
	xcount_t  xcount;

	real  f_period = 7.0;  // ns, 5.71 rising edges per sysclk cycle
	int   cycle_count = 0;

	`include "tb_checks.svh"

	always #(SYSCLK_NS / 2.0) sysclk = ~sysclk;
	always #(f_period / 2.0) f_in = ~f_in;  // follows f_period on every toggle

	freq_meter_top freq_meter_top_inst (
		.sysclk      (sysclk),
		.rst_n       (rst_n),
		.f_in        (f_in),
		.g_in        (g_in),
		.win_sel     (win_sel),
		.frequency   (frequency),
		.freq_strobe (freq_strobe),
		.xcount      (xcount)
	);

	// hang guard
	always @(posedge sysclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d sysclk cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic real random_period();
		return 5.0 + real'($urandom % 31) * 0.5;  // 5 to 20 ns in half-ns steps
	endfunction

	task automatic set_f_period(input real period_ns);
		f_period = period_ns;
	endtask

	task automatic set_window(input win_sel_t sel);
		@(posedge sysclk);
		win_sel <= sel;
	endtask

	task automatic set_gate(input logic level);
		@(posedge f_in);
		g_in <= level;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sysclk);
	endtask

	// gate open for exactly n counted f_in edges
	task automatic pulse_gate(input int n);
		@(posedge f_in);
		g_in <= 1'b1;  // counter sees it from the next edge
		repeat (n) @(posedge f_in);
		g_in <= 1'b0;
	endtask

	// gap is the number of sysclk cycles until freq_strobe, sampled on negedge
	task automatic wait_freq_strobe(output int gap);
		int limit;
		limit = 2 * window_cycles(win_sel) + 8;
		gap = 0;
		do begin
			@(negedge sysclk);
			gap++;
			if (gap > limit)
				abort_run($sformatf("no freq_strobe within two windows at %0t", $time));
		end while (freq_strobe !== 1'b1);
	endtask

	task automatic test_reset_state();
		int gap;
		int win;
		win = window_cycles(win_sel);
		@(negedge sysclk);
		check_freq("frequency", NO_DATA, frequency, 0);
		check_bit("freq_strobe", 1'b0, freq_strobe);
		check_xcount("xcount", '0, xcount);
		gap = 1;
		while (freq_strobe !== 1'b1) begin
			@(negedge sysclk);
			gap++;
			if (freq_strobe === 1'b1 && gap < 2 * win)
				abort_run($sformatf("freq_strobe after %0d cycles, before the second window ended",
					gap));
			if (gap > 2 * win + 4)
				abort_run("first freq_strobe missing after the second window");
		end
	endtask

	// all four lengths, random f_in period for each
	task automatic test_free_running();
		int       gap;
		win_sel_t sel;
		set_gate(1'b1);
		for (int i = 0; i < 4; i++) begin
			sel = win_sel_t'(i);
			set_f_period(random_period());
			set_window(sel);
			wait_cycles(8);         // sync pipeline drains the old rate
			wait_freq_strobe(gap);  // mixed window
			wait_freq_strobe(gap);
			check_freq("frequency", expected_count(window_cycles(sel), f_period), frequency, 1);
		end
	endtask

	task automatic test_fully_gated();
		int gap;
		set_window(win_sel_t'(0));
		set_gate(1'b0);
		wait_cycles(8);
		wait_freq_strobe(gap);
		wait_freq_strobe(gap);  // gate low for the whole window
		check_freq("frequency", '0, frequency, 1);
	endtask

	task automatic test_partial_gating();
		int gap;
		int win;
		int max_edges;
		int n_edges;
		win = window_cycles(win_sel);
		set_f_period(random_period());
		wait_cycles(8);
		wait_freq_strobe(gap);  // a window just opened
		wait_cycles(32);        // margin from the window start
		// burst ends at least 32 cycles before the window does
		max_edges = $rtoi(real'(win - 64) * SYSCLK_NS / f_period);
		n_edges = 16 + int'($urandom % (max_edges - 16));
		pulse_gate(n_edges);
		wait_freq_strobe(gap);
		check_freq("frequency", freq_t'(n_edges), frequency, 1);
		wait_freq_strobe(gap);
		check_freq("frequency", '0, frequency, 1);  // gate closed all window
	endtask

	task automatic test_per_cycle_count();
		int sum;
		int max_per;
		set_f_period(7.0);
		set_gate(1'b1);
		wait_cycles(8);
		max_per = max_per_cycle(f_period);
		sum = 0;
		repeat (100) begin
			@(negedge sysclk);
			if (int'(xcount) > max_per)
				abort_run($sformatf("Mismatch at %0t: xcount expected <= %0d actual %0d",
					$time, max_per, xcount));
			sum += int'(xcount);
		end
		check_freq("xcount sum", expected_count(100, f_period), freq_t'(sum), 2);
	endtask

	task automatic test_window_change();
		int gap;
		set_window(win_sel_t'(1));
		wait_cycles(8);
		wait_freq_strobe(gap);  // window cut by the change
		wait_freq_strobe(gap);
		check_gap("freq_strobe spacing", window_cycles(win_sel), gap);
		check_freq("frequency", expected_count(window_cycles(win_sel), f_period), frequency, 1);
	endtask

	initial begin
		void'($urandom(32'h8ce3_e723));
		repeat (5) @(posedge sysclk);
		rst_n <= 1'b1;
		test_reset_state();
		test_free_running();
		test_fully_gated();
		test_partial_gating();
		test_per_cycle_count();
		test_window_change();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- hdl/freq_meter_top.sv
// single-channel gated frequency meter, f_in measured against sysclk
// frequency updates once per window of the length picked by win_sel
`timescale 1ns/1ps

module freq_meter_top (
	input  logic                     sysclk,       // measurement clock
	input  logic                     rst_n,        // sync to sysclk
	input  logic                     f_in,         // clock under test
	input  logic                     g_in,         // gate, f_in domain
	input  freq_meter_pkg::win_sel_t win_sel,      // window length select
	output freq_meter_pkg::freq_t    frequency,    // edges per full window
	output logic                     freq_strobe,  // one cycle on each new frequency
	output freq_meter_pkg::xcount_t  xcount        // edges per sysclk cycle
);
	import freq_meter_pkg::*;

	logic [GRAY_W-1:0] gray_code;   // f_in domain
	logic              ref_strobe;  // window ends

	// f_in domain
	gray_tick_counter gray_tick_counter_inst (
		.f_in      (f_in),
		.g_in      (g_in),
		.gray_code (gray_code)
	);

	// into sysclk, per-cycle count
	gray_sync_diff gray_sync_diff_inst (
		.sysclk    (sysclk),
		.rst_n     (rst_n),
		.gray_code (gray_code),
		.xcount    (xcount)
	);

	window_strobe_gen window_strobe_gen_inst (
		.sysclk     (sysclk),
		.rst_n      (rst_n),
		.win_sel    (win_sel),
		.ref_strobe (ref_strobe)
	);

	// sums xcount between strobes
	gated_accumulator gated_accumulator_inst (
		.sysclk      (sysclk),
		.rst_n       (rst_n),
		.xcount      (xcount),
		.ref_strobe  (ref_strobe),
		.frequency   (frequency),
		.freq_strobe (freq_strobe)
	);

endmodule

//--- hdl/gated_accumulator.sv
// sums per-cycle counts over a window and publishes the sum on each ref_strobe
// the first window after reset is partial and is thrown away
`timescale 1ns/1ps

module gated_accumulator (
	input  logic                    sysclk,
	input  logic                    rst_n,
	input  freq_meter_pkg::xcount_t xcount,      // edges in this cycle
	input  logic                    ref_strobe,  // window boundary
	output freq_meter_pkg::freq_t   frequency,   // count over the last full window
	output logic                    freq_strobe  // frequency just updated
);
	import freq_meter_pkg::*;

	acq_state_t state;
	freq_t      accum;     // running sum of the window in progress
	freq_t      result;
	logic       strobe_r;

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			state <= ACQ_PRIME;
		end else if (ref_strobe) begin
			case (state)
				ACQ_PRIME: state <= ACQ_RUN;  // partial window ends here
				ACQ_RUN:   state <= ACQ_RUN;
				default:   state <= ACQ_PRIME;
			endcase
		end
	end

	// a strobe cycle's count opens the next window, nothing falls between
	always_ff @(posedge sysclk) begin
		if (!rst_n)
			accum <= '0;
		else if (ref_strobe)
			accum <= freq_t'(xcount);
		else
			accum <= accum + freq_t'(xcount);
	end

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			result   <= FREQ_INIT;  // marks "no measurement yet"
			strobe_r <= 1'b0;
		end else begin
			strobe_r <= 1'b0;
			if (ref_strobe && state == ACQ_RUN) begin
				result   <= accum;  // sum up to the cycle before the strobe
				strobe_r <= 1'b1;
			end
		end
	end

	assign frequency   = result;
	assign freq_strobe = strobe_r;

	// downstream samples on freq_strobe, so it must track the window boundary
	a_strobe_follows_ref: assert property (@(posedge sysclk) disable iff (!rst_n)
		freq_strobe |-> $past(ref_strobe))
		else $error("freq_strobe without a preceding ref_strobe");

	// between strobes the result must hold for late readers
	a_freq_holds: assert property (@(posedge sysclk) disable iff (!rst_n)
		!freq_strobe |-> $stable(frequency))
		else $error("frequency moved without freq_strobe");

endmodule

//--- hdl/window_strobe_gen.sv
// reference window generator, one ref_strobe per window of 2^n sysclk cycles
// n comes from the window table through win_sel, a new select restarts the window
`timescale 1ns/1ps

module window_strobe_gen (
	input  logic                     sysclk,
	input  logic                     rst_n,
	input  freq_meter_pkg::win_sel_t win_sel,    // window length select
	output logic                     ref_strobe  // one cycle at each window end
);
	import freq_meter_pkg::*;

	win_sel_t             sel_q;       // select in use
	logic [WIN_CNT_W-1:0] cnt;
	logic [WIN_CNT_W-1:0] win_last;    // final count of the window
	logic                 sel_change;
	logic                 strobe_r;

	assign win_last   = WIN_CNT_W'((32'd1 << WIN_LOG2_TABLE[sel_q]) - 32'd1);
	assign sel_change = (win_sel != sel_q);

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			sel_q    <= win_sel;  // take the select straight away, no restart after reset
			cnt      <= '0;
			strobe_r <= 1'b0;
		end else if (sel_change) begin
			sel_q    <= win_sel;
			cnt      <= '0;     // start a fresh window
			strobe_r <= 1'b0;   // the cut-short window gets no strobe
		end else if (cnt == win_last) begin
			cnt      <= '0;
			strobe_r <= 1'b1;
		end else begin
			cnt      <= cnt + WIN_CNT_W'(1);
			strobe_r <= 1'b0;
		end
	end

	// registered, so the first strobe lands 2^n cycles after reset release
	assign ref_strobe = strobe_r;

	// the accumulator counts on isolated strobes to mark window boundaries
	a_strobe_single: assert property (@(posedge sysclk) disable iff (!rst_n)
		ref_strobe |=> !ref_strobe)
		else $error("ref_strobe high on consecutive cycles");

endmodule

//--- hdl/gray_sync_diff.sv
// brings the f_in gray count into sysclk and turns it into a per-cycle edge count
// output xcount carries a fresh count every sysclk cycle, zero when nothing moved
`timescale 1ns/1ps

module gray_sync_diff (
	input  logic                              sysclk,
	input  logic                              rst_n,
	input  logic [freq_meter_pkg::GRAY_W-1:0] gray_code,  // f_in domain, one bit per step
	output freq_meter_pkg::xcount_t           xcount      // edges seen in the last cycle
);
	import freq_meter_pkg::*;

	logic [GRAY_W-1:0] gray_s;    // synchronized gray value
	logic [GRAY_W-1:0] bin_s;     // its binary form
	logic [GRAY_W-1:0] bin_cur;   // newest binary sample
	logic [GRAY_W-1:0] bin_prev;  // sample one cycle older
	logic [1:0]        fill;      // cycles since reset, saturates
	logic              primed;
	xcount_t           xcount_r;

	// two flops per bit
	// each bit may resolve late but gray coding keeps the word within one step
	for (genvar i = 0; i < GRAY_W; i++) begin : g_sync
		(* ASYNC_REG = "TRUE" *) logic meta;
		(* ASYNC_REG = "TRUE" *) logic stable;

		always_ff @(posedge sysclk) begin
			if (!rst_n) begin
				meta   <= 1'b0;
				stable <= 1'b0;
			end else begin
				meta   <= gray_code[i];  // may go metastable
				stable <= meta;
			end
		end

		assign gray_s[i] = stable;
	end

	assign bin_s  = gray2bin(gray_s);
	assign primed = &fill;  // sync chain holds real data from here on

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			bin_cur  <= '0;
			bin_prev <= '0;
			fill     <= '0;
			xcount_r <= '0;
		end else begin
			bin_cur <= bin_s;
			// while the chain fills, preload the old sample with the new one
			// so the counter's arbitrary start value gives no burst
			bin_prev <= primed ? bin_cur : bin_s;
			if (!primed)
				fill <= fill + 2'd1;
			xcount_r <= bin_cur - bin_prev;  // modulo 2^GRAY_W, wrap is fine
		end
	end

	assign xcount = xcount_r;

endmodule

//--- hdl/gray_tick_counter.sv
// gated gray-code counter running on the unknown clock f_in
// only one bit moves per edge so the value can be sampled from sysclk
`timescale 1ns/1ps

module gray_tick_counter (
	input  logic                              f_in,       // unknown input clock
	input  logic                              g_in,       // gate, f_in domain
	output logic [freq_meter_pkg::GRAY_W-1:0] gray_code   // free-running gray count
);
	import freq_meter_pkg::*;

	// no reset here, rst_n lives in the sysclk domain
	logic [GRAY_W-1:0] gray_r = '0;
	logic [GRAY_W-1:0] gray_nxt;
	logic              past_ok = 1'b0;  // set after the first f_in edge

	// decode, increment, re-encode
	assign gray_nxt = bin2gray(gray2bin(gray_r) + GRAY_W'(1));

	always_ff @(posedge f_in) begin
		if (g_in)
			gray_r <= gray_nxt;  // advance only while gated on
		past_ok <= 1'b1;
	end

	assign gray_code = gray_r;

	// the sysclk side relies on single-bit steps across the whole f_in history
	a_one_bit_step: assert property (@(posedge f_in)
		past_ok |-> $countones(gray_code ^ $past(gray_code)) <= 1)
		else $error("gray_code moved more than one bit");

endmodule

//--- hdl/freq_meter_pkg.sv
// shared widths, window table, state enum and gray helpers for the frequency meter
// imported by every stage of the meter and by the testbench checks
package freq_meter_pkg;

	localparam int GRAY_W    = 4;   // gray counter and xcount width, under 15 edges per cycle
	localparam int FREQ_W    = 20;  // accumulator and result width
	localparam int WIN_SEL_W = 2;   // window select width
	localparam int WIN_CNT_W = 14;  // window counter width, holds the longest window

	// all ones so a result that was never measured is easy to spot
	localparam logic [FREQ_W-1:0] FREQ_INIT = {FREQ_W{1'b1}};

	// window lengths as log2 of sysclk cycles, indexed by win_sel
	localparam int WIN_LOG2_TABLE [2**WIN_SEL_W] = '{8, 10, 12, 14};

	typedef logic [GRAY_W-1:0]    xcount_t;   // per-cycle edge count
	typedef logic [FREQ_W-1:0]    freq_t;     // count over one window
	typedef logic [WIN_SEL_W-1:0] win_sel_t;  // window length select

	// accumulator warm-up
	typedef enum logic {
		ACQ_PRIME,  // first window after reset is partial and gets dropped
		ACQ_RUN     // full windows, results are published
	} acq_state_t;

	// gray to binary, msb passes through and each lower bit folds in the one above
	function automatic logic [GRAY_W-1:0] gray2bin(input logic [GRAY_W-1:0] g);
		logic [GRAY_W-1:0] b;
		b[GRAY_W-1] = g[GRAY_W-1];
		for (int i = GRAY_W-2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	function automatic logic [GRAY_W-1:0] bin2gray(input logic [GRAY_W-1:0] b);
		return b ^ (b >> 1);
	endfunction

endpackage
